// File: sim.f
+incdir+.
conPkg.sv
conCondDecode.sv
conSkip.sv
conSpecFlags.sv
conCycles.sv
conRunCtl.sv
conTop.sv
conTb.sv

// File: conTbChecks.svh
// LCG for the random status fields
logic [31:0] lcgState = 32'h6a31_c4eb;

function automatic logic [23:0] nextRand();
  lcgState = lcgState * 32'd1664525 + 32'd1013904223;
  // Low LCG bits repeat quickly
  return lcgState[31:8];
endfunction

task automatic checkBit(input string name, input logic got, input logic exp);
  if (got !== exp) begin
    failRun($sformatf("Fail at %0d ns: %s is %b, expected %b", $time, name, got, exp));
  end
endtask

task automatic checkCycles(input cycleState got, input cycleState exp);
  if (got !== exp) begin
    failRun($sformatf("Fail at %0d ns: cycles is %b, expected %b", $time, got, exp));
  end
endtask

task automatic checkFlags(input specFlags got, input specFlags exp);
  if (got !== exp) begin
    failRun($sformatf("Fail at %0d ns: flags is %b, expected %b", $time, got, exp));
  end
endtask

task automatic checkWb(input wbRsp got, input wbRsp exp);
  if (got !== exp) begin
    failRun($sformatf("Fail at %0d ns: wbOut is %h, expected %h", $time, got, exp));
  end
endtask

// File: conTb.sv
`timescale 1ns/1ps

module conTb import conPkg::*; ();

  typedef struct packed {
    microWord  mw;
    mboxStatus mb;
    userStatus us;
    logic      adr10;
    logic      abort;
    cycleState cyc;
    specFlags  fl;
  } tableRow;

  logic      conCLK;
  logic      arstN;
  microWord  microIn;
  mboxStatus mbox;
  userStatus usr;
  wbReq      wbIn;
  wbRsp      wbOut;
  logic      condAdr10;
  cycleState cycles;
  specFlags  flags;
  logic      instrAbort;

  tableRow   rows[$];
  specFlags  modelFlags = '0;
  logic      modelMem = 1'b0;
  logic      modelPi = 1'b0;
  int        cycleCount = 0;
  int        cycleLimit = 200;

  conTop conTop_i (
    .conCLK     (conCLK),
    .arstN      (arstN),
    .microIn    (microIn),
    .mbox       (mbox),
    .usr        (usr),
    .wbIn       (wbIn),
    .wbOut      (wbOut),
    .condAdr10  (condAdr10),
    .cycles     (cycles),
    .flags      (flags),
    .instrAbort (instrAbort)
  );

  task automatic failRun(input string what);
    $display("%s", what);
    $display("Something failed");
    $fatal(1, "Run stopped at the first error");
  endtask

  `include "conTbChecks.svh"

  initial begin
    conCLK = 1'b0;
    forever #20 conCLK = ~conCLK;
  end

  always @(posedge conCLK) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount > cycleLimit) begin
      failRun("Timeout: the run went past its cycle limit");
    end
  end

  function automatic logic skipExpected(input microWord mw, input mboxStatus mb,
                                        input userStatus us);
    logic       kernel;
    logic [7:0] sel6x;
    logic [7:0] sel7x;
    kernel = !us.user && !us.public;
    // Sel 0 at bit 0
    sel6x = {modelFlags.pxct, 1'b0, modelMem, modelPi, us.public, us.user, kernel,
             mb.vmaFetch};
    // Run and start are low before the diagnostic phase
    sel7x = {modelFlags.kernelCycle, mb.acRef, mb.vmaSection0, modelFlags.pxct,
             us.irIoLegal || kernel || modelFlags.kernelCycle || (us.user && us.userIot),
             1'b0, 1'b1, us.intReq && !modelFlags.intDisable};
    if (mw.cond.group == 3'o6) begin
      return sel6x[mw.cond.sel];
    end
    return (mw.cond.group == 3'o7) && sel7x[mw.cond.sel];
  endfunction

  task automatic addRow(input microWord mw, input mboxStatus mb, input userStatus us);
    tableRow row;
    logic    spec;
    logic    waitMem;
    spec      = mw.cond == condSpecInstr;
    waitMem   = mw.memWait && modelMem;
    row.mw    = mw;
    row.mb    = mb;
    row.us    = us;
    row.adr10 = skipExpected(mw, mb, us);
    row.abort = spec && mw.magic.flags.abort;
    row.fl    = modelFlags;
    // No LONG EN, VMA DEC/INC or loadVma in the table so longEn and vmaSel stay low
    row.cyc   = {modelMem, modelPi, waitMem, waitMem && mb.acRef,
                 (mb.vmaFetch && modelMem) || mw.cond == condLoadIr, 1'b0, 2'b00};
    rows.push_back(row);
    if (spec || mw.dispNicond) begin
      modelFlags = mw.magic.flags;
    end
    modelPi  = (spec && mw.magic.flags.piCycleSet) ||
               (modelPi && !mb.skipSatisfied && !(mb.saveFlags && mb.eboxSync));
    modelMem = mb.mboxCycReq || (modelMem && !mb.xfer && !mb.pageError);
  endtask

  task automatic randomRow(input logic [5:0] cond);
    microWord    mw;
    mboxStatus   mb;
    logic [23:0] r1;
    logic [23:0] r2;
    r1 = nextRand();
    r2 = nextRand();
    mw = {cond, r1[8:0], r1[9], r1[10]};
    mb = r2[9:0];
    mb.loadVma = 1'b0;
    // Request and end of cycle kept apart
    if (mb.mboxCycReq) begin
      mb.xfer      = 1'b0;
      mb.pageError = 1'b0;
    end
    addRow(mw, mb, r2[14:10]);
  endtask

  task automatic buildTable();
    microWord  mw;
    mboxStatus mb;
    specFlags  f;
    f  = 9'b011_011_110;
    mw = '0;
    mw.cond        = condSpecInstr;
    mw.magic.flags = f;
    addRow(mw, '0, '0);
    addRow({6'o00, 9'h1a5, 2'b00}, '0, '0);
    addRow({6'o00, 9'h05a, 2'b00}, '0, '0);
    // Memory cycle then FM transfer
    addRow('0, 10'b01_0000_0000, '0);
    addRow({6'o00, 9'h000, 2'b10}, 10'b00_0000_0100, '0);
    addRow({6'o00, 9'h000, 2'b10}, 10'b00_0010_0000, '0);
    addRow({6'o00, 9'h000, 2'b10}, '0, '0);
    // PI cycle in and out
    mw.magic.flags = {1'b1, f[7:3], 1'b0, f[1:0]};
    addRow(mw, '0, '0);
    addRow('0, '0, '0);
    addRow('0, 10'b00_0000_1000, '0);
    addRow('0, '0, '0);
    mb = '0;
    mb.mboxCycReq = 1'b1;
    addRow(mw, mb, '0);
    for (int pass = 0; pass < 2; pass++) begin
      for (int s = 0; s < 8; s++) begin
        randomRow({3'o6, s[2:0]});
        randomRow({3'o7, s[2:0]});
      end
    end
    for (int n = 0; n < 4; n++) begin
      randomRow({n[0] ? 3'o5 : 3'o4, n[2:0]});
    end
  endtask

  task automatic waitAck();
    do begin
      @(posedge conCLK);
      #2;
    end while (!wbOut.ack);
  endtask

  task automatic wbWrite(input logic [7:0] cmd);
    @(posedge conCLK);
    #2;
    wbIn = '{cyc: 1'b1, stb: 1'b1, we: 1'b1, dat: cmd};
    waitAck();
    wbIn = '0;
  endtask

  task automatic wbRead(input logic [7:0] expStatus);
    @(posedge conCLK);
    #2;
    wbIn = '{cyc: 1'b1, stb: 1'b1, we: 1'b0, dat: 8'h00};
    waitAck();
    checkWb(wbOut, '{ack: 1'b1, dat: expStatus});
    wbIn = '0;
    @(posedge conCLK);
    #2;
    checkBit("wbOut.ack", wbOut.ack, 1'b0);
  endtask

  // Skip 72 shows run, which moves 3 cycles after the ack
  task automatic checkRunDelay(input logic level);
    for (int k = 0; k < 4; k++) begin
      if (k > 0) begin
        @(posedge conCLK);
        #2;
      end
      if (k == 1) begin
        checkBit("wbOut.ack", wbOut.ack, 1'b0);
      end
      checkBit("condAdr10 (run)", condAdr10, (k == 3) ? level : !level);
    end
  endtask

  initial begin
    arstN   = 1'b0;
    microIn = '0;
    mbox    = '0;
    usr     = '0;
    wbIn    = '0;
    buildTable();
    // Reset and the Wishbone phase fit in 40 cycles
    cycleLimit = 2 * (rows.size() + 40) + 50;
    repeat (3) @(posedge conCLK);
    #2;
    arstN = 1'b1;
    checkFlags(flags, '0);
    checkCycles(cycles, '0);
    checkBit("wbOut.ack", wbOut.ack, 1'b0);
    wbRead(8'h00);

    foreach (rows[i]) begin
      @(posedge conCLK);
      #2;
      microIn = rows[i].mw;
      mbox    = rows[i].mb;
      usr     = rows[i].us;
      #20;
      checkBit("condAdr10", condAdr10, rows[i].adr10);
      checkBit("instrAbort", instrAbort, rows[i].abort);
      checkCycles(cycles, rows[i].cyc);
      checkFlags(flags, rows[i].fl);
    end

    @(posedge conCLK);
    #2;
    microIn = {6'o72, 9'h000, 2'b00};
    mbox    = '0;
    usr     = '0;
    wbWrite(8'h01 << cmdSetRun);
    checkRunDelay(1'b1);
    wbRead({2'b00, modelFlags.pcPlus1Inh, modelFlags.eboxHalted, modelMem, modelPi,
            1'b0, 1'b1});
    wbWrite(8'h01 << cmdClearRun);
    checkRunDelay(1'b0);

    $display("Everything OK");
    $finish;
  end

endmodule

// File: conTop.sv
`timescale 1ns/1ps

module conTop import conPkg::*; (
  input  logic      conCLK,
  input  logic      arstN,
  input  microWord  microIn,
  input  mboxStatus mbox,
  input  userStatus usr,
  input  wbReq      wbIn,
  output wbRsp      wbOut,
  output logic      condAdr10,
  output cycleState cycles,
  output specFlags  flags,
  output logic      instrAbort
);

  condStrobes strobes;
  logic       run;
  logic       start;

  conCondDecode conCondDecode_i (
    .microIn (microIn),
    .strobes (strobes)
  );

  conSpecFlags conSpecFlags_i (
    .conCLK     (conCLK),
    .arstN      (arstN),
    .strobes    (strobes),
    .microIn    (microIn),
    .flags      (flags),
    .instrAbort (instrAbort)
  );

  conCycles conCycles_i (
    .conCLK  (conCLK),
    .arstN   (arstN),
    .strobes (strobes),
    .microIn (microIn),
    .mbox    (mbox),
    .cycles  (cycles)
  );

  conRunCtl conRunCtl_i (
    .conCLK (conCLK),
    .arstN  (arstN),
    .wbIn   (wbIn),
    .wbOut  (wbOut),
    .cycles (cycles),
    .flags  (flags),
    .run    (run),
    .start  (start)
  );

  conSkip conSkip_i (
    .strobes   (strobes),
    .flags     (flags),
    .cycles    (cycles),
    .mbox      (mbox),
    .usr       (usr),
    .run       (run),
    .start     (start),
    .condAdr10 (condAdr10)
  );

endmodule

// File: conRunCtl.sv
`timescale 1ns/1ps

module conRunCtl import conPkg::*; (
  input  logic      conCLK,
  input  logic      arstN,
  input  wbReq      wbIn,
  output wbRsp      wbOut,
  input  cycleState cycles,
  input  specFlags  flags,
  output logic      run,
  output logic      start
);

  logic       ackQ;
  logic       req;
  logic       wrReq;
  logic       setRun;
  logic       clearRun;
  logic       continueCmd;
  logic       consoleFunc;
  logic       runState;
  logic       startState;
  logic [2:0] runPipe;
  logic [2:0] startPipe;
  logic [7:0] status;
  magicWord   latched;

  // New request only while ack is low
  assign req   = wbIn.cyc && wbIn.stb && !ackQ;
  assign wrReq = req && wbIn.we;

  // Latched MAGIC read as a diag function code
  assign latched.flags = flags;
  assign consoleFunc   = latched.func.high == 3'o0;

  assign setRun      = wrReq && wbIn.dat[cmdSetRun];
  assign clearRun    = wrReq && wbIn.dat[cmdClearRun];
  // Continue only from the console 0xx range
  assign continueCmd = wrReq && wbIn.dat[cmdContinue] && consoleFunc;

  always_ff @(posedge conCLK or negedge arstN) begin
    if (!arstN) begin
      ackQ       <= 1'b0;
      runState   <= 1'b0;
      startState <= 1'b0;
      runPipe    <= '0;
      startPipe  <= '0;
    end else begin
      ackQ <= req;
      if (setRun) begin
        runState <= 1'b1;
      end else if (clearRun) begin
        runState <= 1'b0;
      end
      startState <= startState ^ continueCmd;
      runPipe    <= {runPipe[1:0], runState};
      startPipe  <= {startPipe[1:0], startState};
    end
  end

  assign run   = runPipe[2];
  assign start = startPipe[2];

  assign status = {cycles.mboxWait, cycles.longEn, flags.pcPlus1Inh, flags.eboxHalted,
                   cycles.memCycle, cycles.piCycle, start, run};

  always_comb begin
    wbOut.ack = ackQ;
    wbOut.dat = ackQ ? status : '0;
  end

  // Ack answers a request and drops after one cycle
  ackOneCycle: assert property (
    @(posedge conCLK) disable iff (!arstN)
    $rose(wbOut.ack) |-> $past(wbIn.cyc && wbIn.stb) ##1 !wbOut.ack
  ) else $error("conRunCtl: ack not a single-cycle reply");

endmodule

// File: conCycles.sv
`timescale 1ns/1ps

module conCycles import conPkg::*; (
  input  logic       conCLK,
  input  logic       arstN,
  input  condStrobes strobes,
  input  microWord   microIn,
  input  mboxStatus  mbox,
  output cycleState  cycles
);

  logic memCycle;
  logic piCycle;
  logic longEn;
  logic clrPiCycle;
  logic setPiCycle;
  logic mboxWait;
  logic fetchCycle;

  // PI cycle ends when flags are saved in sync with the EBOX
  assign clrPiCycle = mbox.saveFlags && mbox.eboxSync;
  assign setPiCycle = strobes.specInstr && microIn.magic.flags.piCycleSet;

  always_ff @(posedge conCLK or negedge arstN) begin
    if (!arstN) begin
      memCycle <= 1'b0;
      piCycle  <= 1'b0;
      longEn   <= 1'b0;
    end else begin
      memCycle <= mbox.mboxCycReq ||
                  (memCycle && !mbox.xfer && !mbox.pageError);
      piCycle  <= setPiCycle ||
                  (piCycle && !mbox.skipSatisfied && !clrPiCycle);
      // Long enable only outside section 0, held until the next request
      longEn   <= (strobes.longEn && !mbox.vmaSection0) ||
                  (longEn && !mbox.mboxCycReq);
    end
  end

  assign mboxWait   = microIn.memWait && memCycle;
  assign fetchCycle = mbox.vmaFetch && memCycle;

  always_comb begin
    cycles.memCycle  = memCycle;
    cycles.piCycle   = piCycle;
    cycles.mboxWait  = mboxWait;
    cycles.fmXfer    = mboxWait && mbox.acRef;
    cycles.loadIr    = fetchCycle || strobes.loadIr;
    cycles.longEn    = longEn;
    cycles.vmaSel[1] = strobes.vmaDec || mbox.loadVma;
    cycles.vmaSel[0] = strobes.vmaInc || mbox.loadVma;
  end

  // A fast-memory transfer only happens inside a requested memory cycle
  fmXferInCycle: assert property (
    @(posedge conCLK) disable iff (!arstN)
    cycles.fmXfer |-> $past(mbox.mboxCycReq) || $past(memCycle)
  ) else $error("conCycles: fmXfer outside a memory cycle");

endmodule

// File: conSpecFlags.sv
`timescale 1ns/1ps

module conSpecFlags import conPkg::*; (
  input  logic       conCLK,
  input  logic       arstN,
  input  condStrobes strobes,
  input  microWord   microIn,
  output specFlags   flags,
  output logic       instrAbort
);

  logic                  load;
  logic [magicWidth-1:0] flagBits;

  // SPEC INSTR or a NICOND dispatch loads the flags
  assign load = strobes.specInstr || microIn.dispNicond;

  always_ff @(posedge conCLK or negedge arstN) begin
    if (!arstN) begin
      flagBits <= '0;
    end else if (load) begin
      flagBits <= microIn.magic.flags;
    end
  end

  assign flags = flagBits;

  // Abort comes straight from the current microword
  assign instrAbort = strobes.specInstr && microIn.magic.flags.abort;

  // Flags hold between loads
  flagsHeld: assert property (
    @(posedge conCLK) disable iff (!arstN)
    !load |=> $stable(flags)
  ) else $error("conSpecFlags: flags changed without a load");

endmodule

// File: conSkip.sv
`timescale 1ns/1ps

module conSkip import conPkg::*; (
  input  condStrobes strobes,
  input  specFlags   flags,
  input  cycleState  cycles,
  input  mboxStatus  mbox,
  input  userStatus  usr,
  input  logic       run,
  input  logic       start,
  output logic       condAdr10
);

  logic       kernel;
  logic       ioLegal;
  logic       intReq;
  logic [7:0] cond6x;
  logic [7:0] cond7x;

  // Kernel mode is neither user nor public
  assign kernel = !usr.user && !usr.public;

  assign ioLegal = usr.irIoLegal || kernel || flags.kernelCycle ||
                   (usr.user && usr.userIot);

  assign intReq = usr.intReq && !flags.intDisable;

  // Index is the sel field, 60 at bit 0
  assign cond6x = {flags.pxct,
                   cycles.longEn,
                   cycles.memCycle,
                   cycles.piCycle,
                   usr.public,
                   usr.user,
                   kernel,
                   mbox.vmaFetch};

  assign cond7x = {flags.kernelCycle,
                   mbox.acRef,
                   mbox.vmaSection0,
                   flags.pxct,
                   ioLegal,
                   run,
                   !start,
                   intReq};

  // Next-address bit 10
  assign condAdr10 = (strobes.skip6x && cond6x[strobes.sel]) ||
                     (strobes.skip7x && cond7x[strobes.sel]);

endmodule

// File: conCondDecode.sv
`timescale 1ns/1ps

module conCondDecode import conPkg::*; (
  input  microWord   microIn,
  output condStrobes strobes
);

  condField cond;
  logic     in10;
  logic     in20;
  logic     in30;

  assign cond = microIn.cond;

  // Group enables for the non-skip groups
  assign in10 = cond.group == condGrp10;
  assign in20 = cond.group == condGrp20;
  assign in30 = cond.group == condGrp30;

  always_comb begin
    strobes = '0;
    strobes.en00 = cond.group == 3'o0;

    // 10 group
    strobes.loadIr    = in10 && cond.sel == condLoadIr[2:0];
    strobes.specInstr = in10 && cond.sel == condSpecInstr[2:0];
    strobes.srMagic   = in10 && cond.sel == condSrMagic[2:0];
    strobes.selVma    = in10 && cond.sel == condSelVma[2:0];

    // 20 group
    strobes.diagFunc = in20 && cond.sel == condDiagFunc[2:0];
    strobes.longEn   = in20 && cond.sel == condLongEn[2:0];

    // 30 group
    strobes.vmaDec = in30 && cond.sel == condVmaDec[2:0];
    strobes.vmaInc = in30 && cond.sel == condVmaInc[2:0];

    // Skip groups, sel picks the condition downstream
    strobes.skip6x = cond.group == condGrp60;
    strobes.skip7x = cond.group == condGrp70;
    strobes.sel    = cond.sel;
  end

  // One microword never raises two condition strobes across groups
  always_comb begin
    assert final ($onehot0({strobes.en00, strobes.loadIr, strobes.specInstr,
                            strobes.srMagic, strobes.selVma, strobes.diagFunc,
                            strobes.longEn, strobes.vmaDec, strobes.vmaInc,
                            strobes.skip6x, strobes.skip7x}))
      else $error("conCondDecode: more than one COND strobe set");
  end

endmodule

// File: conPkg.sv
package conPkg;

  // Microword field widths
  localparam int condWidth  = 6;
  localparam int magicWidth = 9;

  // Octal COND groups, upper three bits of COND
  localparam logic [2:0] condGrp10 = 3'o1;
  localparam logic [2:0] condGrp20 = 3'o2;
  localparam logic [2:0] condGrp30 = 3'o3;
  localparam logic [2:0] condGrp60 = 3'o6;
  localparam logic [2:0] condGrp70 = 3'o7;

  // COND values decoded into strobes
  localparam logic [condWidth-1:0] condLoadIr    = 6'o14;
  localparam logic [condWidth-1:0] condSpecInstr = 6'o15;
  localparam logic [condWidth-1:0] condSrMagic   = 6'o16;
  localparam logic [condWidth-1:0] condSelVma    = 6'o17;
  localparam logic [condWidth-1:0] condDiagFunc  = 6'o20;
  localparam logic [condWidth-1:0] condLongEn    = 6'o25;
  localparam logic [condWidth-1:0] condVmaDec    = 6'o35;
  localparam logic [condWidth-1:0] condVmaInc    = 6'o36;

  // Command bits in a diagnostic write
  localparam int cmdClearRun = 0;
  localparam int cmdSetRun   = 1;
  localparam int cmdContinue = 2;

  typedef struct packed {
    logic [2:0] group;
    logic [2:0] sel;
  } condField;

  // MAGIC bit 0 is the MSB here
  typedef struct packed {
    logic piCycleSet;
    logic kernelCycle;
    logic pcPlus1Inh;
    logic spare3;
    logic pxct;
    logic intDisable;
    logic abort;
    logic eboxHalted;
    logic spare8;
  } specFlags;

  typedef struct packed {
    logic [2:0] high;
    logic [2:0] func;
    logic [2:0] sub;
  } diagFunc;

  // Flags for SPEC INSTR, function code for DIAG FUNC
  typedef union packed {
    specFlags flags;
    diagFunc  func;
  } magicWord;

  typedef struct packed {
    condField cond;
    magicWord magic;
    logic     memWait;
    logic     dispNicond;
  } microWord;

  typedef struct packed {
    logic       en00;
    logic       loadIr;
    logic       specInstr;
    logic       srMagic;
    logic       selVma;
    logic       diagFunc;
    logic       longEn;
    logic       vmaDec;
    logic       vmaInc;
    logic       skip6x;
    logic       skip7x;
    logic [2:0] sel;
  } condStrobes;

  typedef struct packed {
    logic vmaFetch;
    logic mboxCycReq;
    logic loadVma;
    logic vmaSection0;
    logic xfer;
    logic pageError;
    logic skipSatisfied;
    logic acRef;
    logic eboxSync;
    logic saveFlags;
  } mboxStatus;

  typedef struct packed {
    logic user;
    logic public;
    logic userIot;
    logic irIoLegal;
    logic intReq;
  } userStatus;

  typedef struct packed {
    logic       memCycle;
    logic       piCycle;
    logic       mboxWait;
    logic       fmXfer;
    logic       loadIr;
    logic       longEn;
    logic [1:0] vmaSel;
  } cycleState;

  typedef struct packed {
    logic       cyc;
    logic       stb;
    logic       we;
    logic [7:0] dat;
  } wbReq;

  typedef struct packed {
    logic       ack;
    logic [7:0] dat;
  } wbRsp;

endpackage
